// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ----------------------------------------
// Memory geometry
// ----------------------------------------

// Width of one SRAM word and of the boot stream
`define MEM_DATA_W 32

// Word address width, byte address bits 11 to 2
`define MEM_ADDR_W 10

// Words per SRAM, upper bound for each image length
`define IMEM_DEPTH 1024
`define DMEM_DEPTH 1024

`endif

// File: boot_pkg.sv
`include "mem_settings.svh"

package boot_pkg;

	// ----------------------------------------
	// Boot stream layout
	// ----------------------------------------

	// First stream word, image lengths in words
	typedef struct packed {
		logic [15:0] imem_words;
		logic [15:0] dmem_words;
	} boot_hdr_t;

	// Same stream word seen as header or as image data
	typedef union packed {
		logic [`MEM_DATA_W-1:0] raw;
		boot_hdr_t              hdr;
	} boot_word_u;

	// Loader FSM
	typedef enum logic [1:0] {
		WAIT_HDR  = 2'd0,
		LOAD_IMEM = 2'd1,
		LOAD_DMEM = 2'd2,
		DONE      = 2'd3
	} boot_state_e;

endpackage

// File: obi_pkg.sv
`include "mem_settings.svh"

package obi_pkg;

	// ----------------------------------------
	// OBI transfer fields
	// ----------------------------------------

	// Byte address as seen by the core
	typedef logic [31:0] obi_addr_t;

	// One enable per byte lane
	typedef logic [3:0] obi_be_t;

	// SRAM word address
	typedef logic [`MEM_ADDR_W-1:0] word_addr_t;

	// Drop the byte offset, keep bits 11 to 2
	function automatic word_addr_t to_word_addr(obi_addr_t byte_addr);
		return byte_addr[`MEM_ADDR_W+1:2];
	endfunction

endpackage

// File: ssram.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module ssram (
	input  logic                   tb_CLK,
	input  logic                   csb,
	input  logic                   web,
	input  obi_pkg::word_addr_t    addr,
	input  obi_pkg::obi_be_t       be,
	input  logic [`MEM_DATA_W-1:0] din,
	output logic [`MEM_DATA_W-1:0] dout
);

	localparam int N_BYTES = `MEM_DATA_W / 8;

	// Storage, no reset
	logic [`MEM_DATA_W-1:0] mem [0:(1 << `MEM_ADDR_W)-1];

	// ----------------------------------------
	// Write port with byte masks
	// ----------------------------------------
	always_ff @(posedge tb_CLK) begin
		if (!csb && !web) begin
			for (int i = 0; i < N_BYTES; i++) begin
				if (be[i]) begin
					mem[addr][i*8 +: 8] <= din[i*8 +: 8];
				end
			end
		end
	end

	// ----------------------------------------
	// Registered read
	// ----------------------------------------

	// dout keeps the last read word otherwise
	always_ff @(posedge tb_CLK) begin
		if (!csb && web) begin
			dout <= mem[addr];
		end
	end

endmodule

// File: obi_ssram_bridge.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module obi_ssram_bridge (
	input  logic                   tb_CLK,
	input  logic                   reset,
	input  logic                   core_reset,

	// OBI side
	input  logic                   req,
	output logic                   gnt,
	input  obi_pkg::obi_addr_t     addr,
	input  logic                   we,
	input  obi_pkg::obi_be_t       be,
	input  logic [`MEM_DATA_W-1:0] wdata,
	output logic                   rvalid,
	output logic [`MEM_DATA_W-1:0] rdata,

	// Preload side
	input  logic                   pre_we,
	input  obi_pkg::word_addr_t    pre_addr,
	input  logic [`MEM_DATA_W-1:0] pre_wdata
);

	import obi_pkg::*;

	logic                   sram_csb;
	logic                   sram_web;
	word_addr_t             sram_addr;
	obi_be_t                sram_be;
	logic [`MEM_DATA_W-1:0] sram_din;
	logic [`MEM_DATA_W-1:0] sram_dout;

	// Core held in reset gets no grant
	assign gnt = req && !core_reset;

	// ----------------------------------------
	// SRAM cycle select
	// ----------------------------------------

	// Preload owns the SRAM while booting
	always_comb begin
		if (core_reset) begin
			sram_csb  = !pre_we;
			sram_web  = !pre_we;
			sram_addr = pre_addr;
			sram_be   = '1;
			sram_din  = pre_wdata;
		end else begin
			sram_csb  = !gnt;
			sram_web  = !we;
			sram_addr = to_word_addr(addr);
			sram_be   = be;
			sram_din  = wdata;
		end
	end

	ssram u_ssram (
		.tb_CLK (tb_CLK),
		.csb    (sram_csb),
		.web    (sram_web),
		.addr   (sram_addr),
		.be     (sram_be),
		.din    (sram_din),
		.dout   (sram_dout)
	);

	// ----------------------------------------
	// Response
	// ----------------------------------------

	// One response per grant, one cycle later
	always_ff @(posedge tb_CLK) begin
		if (reset) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= gnt;
		end
	end

	// Read word straight from the SRAM register, ignored on writes
	assign rdata = sram_dout;

endmodule

// File: mem_boot_loader.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_boot_loader (
	input  logic                   tb_CLK,
	input  logic                   reset,

	// Boot stream
	input  logic                   boot_valid,
	output logic                   boot_ready,
	input  logic [`MEM_DATA_W-1:0] boot_data,

	// Preload port and core reset
	output logic                   core_reset,
	output logic                   imem_we,
	output logic                   dmem_we,
	output obi_pkg::word_addr_t    pre_addr,
	output logic [`MEM_DATA_W-1:0] pre_wdata
);

	import boot_pkg::*;
	import obi_pkg::*;

	boot_state_e state;
	boot_state_e state_nx;
	boot_word_u  word;
	logic [15:0] hdr_imem;
	logic [15:0] hdr_dmem;
	logic [15:0] imem_left;
	logic [15:0] dmem_left;
	word_addr_t  wr_addr;
	logic        accept;

	assign word   = boot_data;
	assign accept = boot_valid && boot_ready;

	// Lengths limited to the SRAM depths
	assign hdr_imem = (word.hdr.imem_words > `IMEM_DEPTH) ? 16'(`IMEM_DEPTH)
	                                                      : word.hdr.imem_words;
	assign hdr_dmem = (word.hdr.dmem_words > `DMEM_DEPTH) ? 16'(`DMEM_DEPTH)
	                                                      : word.hdr.dmem_words;

	// ----------------------------------------
	// Next state
	// ----------------------------------------
	always_comb begin
		state_nx = state;
		case (state)
			WAIT_HDR: begin
				if (accept) begin
					// Empty sections are skipped
					if (hdr_imem != '0) begin
						state_nx = LOAD_IMEM;
					end else if (hdr_dmem != '0) begin
						state_nx = LOAD_DMEM;
					end else begin
						state_nx = DONE;
					end
				end
			end
			LOAD_IMEM: begin
				if (accept && imem_left == 16'd1) begin
					state_nx = (dmem_left != '0) ? LOAD_DMEM : DONE;
				end
			end
			LOAD_DMEM: begin
				if (accept && dmem_left == 16'd1) begin
					state_nx = DONE;
				end
			end
			default: begin
				state_nx = DONE;
			end
		endcase
	end

	// ----------------------------------------
	// Control registers
	// ----------------------------------------
	always_ff @(posedge tb_CLK) begin
		if (reset) begin
			state      <= WAIT_HDR;
			boot_ready <= 1'b0;
			core_reset <= 1'b1;
			imem_we    <= 1'b0;
			dmem_we    <= 1'b0;
			imem_left  <= '0;
			dmem_left  <= '0;
			wr_addr    <= '0;
		end else begin
			state      <= state_nx;
			boot_ready <= (state_nx != DONE);
			imem_we    <= accept && (state == LOAD_IMEM);
			dmem_we    <= accept && (state == LOAD_DMEM);

			// Release once the last strobe has reached the SRAM
			if (state == DONE && !imem_we && !dmem_we) begin
				core_reset <= 1'b0;
			end

			if (accept) begin
				case (state)
					WAIT_HDR: begin
						imem_left <= hdr_imem;
						dmem_left <= hdr_dmem;
						wr_addr   <= '0;
					end
					LOAD_IMEM: begin
						imem_left <= imem_left - 16'd1;
						// Data section starts again at word 0
						wr_addr   <= (imem_left == 16'd1) ? '0 : wr_addr + 1'b1;
					end
					LOAD_DMEM: begin
						dmem_left <= dmem_left - 16'd1;
						wr_addr   <= wr_addr + 1'b1;
					end
					default: begin
						wr_addr <= wr_addr;
					end
				endcase
			end
		end
	end

	// Write payload, header words are never strobed
	always_ff @(posedge tb_CLK) begin
		if (accept) begin
			pre_addr  <= wr_addr;
			pre_wdata <= word.raw;
		end
	end

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module mem_subsys_top (
	input  logic                   tb_CLK,
	input  logic                   reset,

	// Boot stream
	input  logic                   boot_valid,
	output logic                   boot_ready,
	input  logic [`MEM_DATA_W-1:0] boot_data,
	output logic                   core_reset,

	// Fetch port
	input  logic                   fetch_req,
	output logic                   fetch_gnt,
	input  obi_pkg::obi_addr_t     fetch_addr,
	input  logic                   fetch_we,
	input  obi_pkg::obi_be_t       fetch_be,
	input  logic [`MEM_DATA_W-1:0] fetch_wdata,
	output logic                   fetch_rvalid,
	output logic [`MEM_DATA_W-1:0] fetch_rdata,

	// Load/store port
	input  logic                   lsu_req,
	output logic                   lsu_gnt,
	input  obi_pkg::obi_addr_t     lsu_addr,
	input  logic                   lsu_we,
	input  obi_pkg::obi_be_t       lsu_be,
	input  logic [`MEM_DATA_W-1:0] lsu_wdata,
	output logic                   lsu_rvalid,
	output logic [`MEM_DATA_W-1:0] lsu_rdata
);

	import obi_pkg::*;

	logic                   imem_we;
	logic                   dmem_we;
	word_addr_t             pre_addr;
	logic [`MEM_DATA_W-1:0] pre_wdata;

	// ----------------------------------------
	// Flashing logic
	// ----------------------------------------
	mem_boot_loader u_boot_loader (
		.tb_CLK     (tb_CLK),
		.reset      (reset),
		.boot_valid (boot_valid),
		.boot_ready (boot_ready),
		.boot_data  (boot_data),
		.core_reset (core_reset),
		.imem_we    (imem_we),
		.dmem_we    (dmem_we),
		.pre_addr   (pre_addr),
		.pre_wdata  (pre_wdata)
	);

	// ----------------------------------------
	// Instruction side
	// ----------------------------------------
	obi_ssram_bridge u_fetch_bridge (
		.tb_CLK     (tb_CLK),
		.reset      (reset),
		.core_reset (core_reset),
		.req        (fetch_req),
		.gnt        (fetch_gnt),
		.addr       (fetch_addr),
		.we         (fetch_we),
		.be         (fetch_be),
		.wdata      (fetch_wdata),
		.rvalid     (fetch_rvalid),
		.rdata      (fetch_rdata),
		.pre_we     (imem_we),
		.pre_addr   (pre_addr),
		.pre_wdata  (pre_wdata)
	);

	// ----------------------------------------
	// Data side
	// ----------------------------------------
	obi_ssram_bridge u_lsu_bridge (
		.tb_CLK     (tb_CLK),
		.reset      (reset),
		.core_reset (core_reset),
		.req        (lsu_req),
		.gnt        (lsu_gnt),
		.addr       (lsu_addr),
		.we         (lsu_we),
		.be         (lsu_be),
		.wdata      (lsu_wdata),
		.rvalid     (lsu_rvalid),
		.rdata      (lsu_rdata),
		.pre_we     (dmem_we),
		.pre_addr   (pre_addr),
		.pre_wdata  (pre_wdata)
	);

endmodule

// File: tb_mem_subsys_checker.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module tb_mem_subsys_checker (
	input logic                   tb_CLK,
	input logic                   reset,
	input logic                   core_reset,
	input logic                   boot_valid,
	input logic                   boot_ready,
	input logic [`MEM_DATA_W-1:0] boot_data,
	input logic                   fetch_gnt,
	input logic                   fetch_rvalid,
	input logic                   lsu_gnt,
	input logic                   lsu_rvalid
);

	// ----------------------------------------
	// OBI ports
	// ----------------------------------------
	assert property (@(posedge tb_CLK) disable iff (reset)
		core_reset |-> !fetch_gnt && !lsu_gnt)
	else $error("grant while core_reset is high");

	assert property (@(posedge tb_CLK) disable iff (reset) fetch_gnt |=> fetch_rvalid)
	else $error("fetch_rvalid missing after fetch_gnt");

	assert property (@(posedge tb_CLK) disable iff (reset) fetch_rvalid |-> $past(fetch_gnt))
	else $error("fetch_rvalid without fetch_gnt one cycle earlier");

	assert property (@(posedge tb_CLK) disable iff (reset) lsu_gnt |=> lsu_rvalid)
	else $error("lsu_rvalid missing after lsu_gnt");

	assert property (@(posedge tb_CLK) disable iff (reset) lsu_rvalid |-> $past(lsu_gnt))
	else $error("lsu_rvalid without lsu_gnt one cycle earlier");

	// ----------------------------------------
	// Boot stream
	// ----------------------------------------
	assert property (@(posedge tb_CLK) disable iff (reset) !core_reset |-> !boot_ready)
	else $error("boot_ready high after core release");

	assert property (@(posedge tb_CLK) disable iff (reset)
		boot_valid && !boot_ready |=> boot_valid && $stable(boot_data))
	else $error("boot word dropped or changed before acceptance");

endmodule

bind mem_subsys_top tb_mem_subsys_checker u_checker (
	.tb_CLK       (tb_CLK),
	.reset        (reset),
	.core_reset   (core_reset),
	.boot_valid   (boot_valid),
	.boot_ready   (boot_ready),
	.boot_data    (boot_data),
	.fetch_gnt    (fetch_gnt),
	.fetch_rvalid (fetch_rvalid),
	.lsu_gnt      (lsu_gnt),
	.lsu_rvalid   (lsu_rvalid)
);

// File: tb_mem_subsys.sv
`timescale 1ns/1ns
`include "mem_settings.svh"

module tb_mem_subsys;

	import boot_pkg::*;
	import obi_pkg::*;

	localparam int N_WRITES = 24;

	logic                   tb_CLK;
	logic                   reset;
	logic                   boot_valid;
	logic                   boot_ready;
	logic [`MEM_DATA_W-1:0] boot_data;
	logic                   core_reset;
	logic                   fetch_req;
	logic                   fetch_gnt;
	obi_addr_t              fetch_addr;
	logic                   fetch_we;
	obi_be_t                fetch_be;
	logic [`MEM_DATA_W-1:0] fetch_wdata;
	logic                   fetch_rvalid;
	logic [`MEM_DATA_W-1:0] fetch_rdata;
	logic                   lsu_req;
	logic                   lsu_gnt;
	obi_addr_t              lsu_addr;
	logic                   lsu_we;
	obi_be_t                lsu_be;
	logic [`MEM_DATA_W-1:0] lsu_wdata;
	logic                   lsu_rvalid;
	logic [`MEM_DATA_W-1:0] lsu_rdata;

	// Reference memories indexed by word address
	logic [`MEM_DATA_W-1:0] imem_ref [int];
	logic [`MEM_DATA_W-1:0] dmem_ref [int];

	// Expected responses for fetch (0) and lsu (1)
	// Top bit set for a read
	logic [`MEM_DATA_W:0] pend_q [2][$];

	logic [31:0] rng_state = 32'h710c;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int          n_checks = 0;
	int          n_mismatch = 0;
	int          n_fail = 0;
	int          n_imem;
	int          n_dmem;
	int          last_accept;

	// Monitor sampling
	logic                   m_req;
	logic                   m_gnt;
	logic                   m_we;
	logic                   m_rvalid;
	obi_addr_t              m_addr;
	obi_be_t                m_be;
	logic [`MEM_DATA_W-1:0] m_wdata;
	logic [`MEM_DATA_W-1:0] m_rdata;
	logic [`MEM_DATA_W:0]   m_entry;
	int                     m_word;

	mem_subsys_top DUT (
		.tb_CLK       (tb_CLK),
		.reset        (reset),
		.boot_valid   (boot_valid),
		.boot_ready   (boot_ready),
		.boot_data    (boot_data),
		.core_reset   (core_reset),
		.fetch_req    (fetch_req),
		.fetch_gnt    (fetch_gnt),
		.fetch_addr   (fetch_addr),
		.fetch_we     (fetch_we),
		.fetch_be     (fetch_be),
		.fetch_wdata  (fetch_wdata),
		.fetch_rvalid (fetch_rvalid),
		.fetch_rdata  (fetch_rdata),
		.lsu_req      (lsu_req),
		.lsu_gnt      (lsu_gnt),
		.lsu_addr     (lsu_addr),
		.lsu_we       (lsu_we),
		.lsu_be       (lsu_be),
		.lsu_wdata    (lsu_wdata),
		.lsu_rvalid   (lsu_rvalid),
		.lsu_rdata    (lsu_rdata)
	);

	initial begin
		tb_CLK = 1'b0;
		forever #5 tb_CLK = ~tb_CLK;
	end

	// ----------------------------------------
	// Error accounting
	// ----------------------------------------
	task automatic report_mismatch(input string sig, input logic [31:0] got,
	                               input logic [31:0] exp);
		n_mismatch++;
		$display("mismatch %s: got %h, expected %h", sig, got, exp);
	endtask

	task automatic report_failure(input string what);
		n_fail++;
		$display("error: %s", what);
	endtask

	task automatic check_bit(input string sig, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			report_mismatch(sig, 32'(got), 32'(exp));
		end
	endtask

	task automatic finish_run();
		if (pend_q[0].size() + pend_q[1].size() != 0) begin
			report_failure("responses still outstanding at the end of the run");
		end
		$display("checks %0d, mismatches %0d, other errors %0d",
		         n_checks, n_mismatch, n_fail);
		if (n_mismatch + n_fail == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// LCG with the Numerical Recipes constants
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic logic [31:0] expected_read(input bit is_lsu, input int waddr);
		if (is_lsu && dmem_ref.exists(waddr)) begin
			return dmem_ref[waddr];
		end
		if (!is_lsu && imem_ref.exists(waddr)) begin
			return imem_ref[waddr];
		end
		return 'x;
	endfunction

	// Enabled lanes take the new byte
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
	                                            input logic [31:0] new_word,
	                                            input logic [3:0] be);
		logic [31:0] result;
		result = old_word;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) begin
				result[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return result;
	endfunction

	// Responses are checked before this cycle's grant is queued
	always @(negedge tb_CLK) begin
		if (!reset) begin
			for (int p = 0; p < 2; p++) begin
				m_req    = (p == 1) ? lsu_req : fetch_req;
				m_gnt    = (p == 1) ? lsu_gnt : fetch_gnt;
				m_we     = (p == 1) ? lsu_we : fetch_we;
				m_addr   = (p == 1) ? lsu_addr : fetch_addr;
				m_be     = (p == 1) ? lsu_be : fetch_be;
				m_wdata  = (p == 1) ? lsu_wdata : fetch_wdata;
				m_rvalid = (p == 1) ? lsu_rvalid : fetch_rvalid;
				m_rdata  = (p == 1) ? lsu_rdata : fetch_rdata;
				m_word   = int'(m_addr[`MEM_ADDR_W+1:2]);
				if (m_rvalid && pend_q[p].size() == 0) begin
					report_failure($sformatf("unexpected rvalid on port %0d", p));
				end else if (m_rvalid) begin
					m_entry = pend_q[p].pop_front();
					n_checks++;
					if (m_entry[`MEM_DATA_W] && m_rdata !== m_entry[`MEM_DATA_W-1:0]) begin
						report_mismatch((p == 1) ? "lsu_rdata" : "fetch_rdata", m_rdata,
						                m_entry[`MEM_DATA_W-1:0]);
					end
				end else if (pend_q[p].size() != 0) begin
					report_failure($sformatf("no rvalid on port %0d after grant", p));
					void'(pend_q[p].pop_front());
				end
				if (m_gnt && core_reset) begin
					report_failure("grant while the core is held in reset");
				end
				if (m_req && m_gnt && m_we) begin
					if (p == 1) begin
						dmem_ref[m_word] = merge_bytes(expected_read(1'b1, m_word),
						                               m_wdata, m_be);
					end else begin
						imem_ref[m_word] = merge_bytes(expected_read(1'b0, m_word),
						                               m_wdata, m_be);
					end
					pend_q[p].push_back({1'b0, 32'h0});
				end else if (m_req && m_gnt) begin
					pend_q[p].push_back({1'b1, expected_read(p == 1, m_word)});
				end
			end
		end
	end

	always @(posedge tb_CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			report_failure($sformatf("run did not finish within %0d cycles", cycle_limit));
			finish_run();
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	task automatic apply_reset();
		reset <= 1'b1;
		repeat (10) @(posedge tb_CLK);
		reset <= 1'b0;
	endtask

	// Reads of word 0 held on both ports until the core leaves reset
	task automatic park_requests();
		fetch_req  <= 1'b1;
		fetch_we   <= 1'b0;
		fetch_addr <= '0;
		fetch_be   <= 4'hf;
		lsu_req    <= 1'b1;
		lsu_we     <= 1'b0;
		lsu_addr   <= '0;
		lsu_be     <= 4'hf;
	endtask

	task automatic check_idle_after_reset();
		@(negedge tb_CLK);
		check_bit("core_reset", core_reset, 1'b1);
		check_bit("fetch_gnt", fetch_gnt, 1'b0);
		check_bit("lsu_gnt", lsu_gnt, 1'b0);
		check_bit("fetch_rvalid", fetch_rvalid, 1'b0);
		check_bit("lsu_rvalid", lsu_rvalid, 1'b0);
		@(negedge tb_CLK);
		check_bit("boot_ready", boot_ready, 1'b1);
		@(posedge tb_CLK);
	endtask

	// Header and both images with random idle cycles between words
	task automatic send_boot(input int n_i, input int n_d, output int accept_edge);
		logic [31:0] words [$];
		logic [31:0] w;
		logic [31:0] r;
		boot_hdr_t   hdr;
		int          idx;
		bit          busy;
		hdr.imem_words = 16'(n_i);
		hdr.dmem_words = 16'(n_d);
		words.push_back(hdr);
		for (int i = 0; i < n_i; i++) begin
			w = next_rand();
			imem_ref[i] = w;
			words.push_back(w);
		end
		for (int i = 0; i < n_d; i++) begin
			w = next_rand();
			dmem_ref[i] = w;
			words.push_back(w);
		end
		idx = 0;
		busy = 1'b0;
		accept_edge = 0;
		while (idx < words.size()) begin
			if (!busy) begin
				r = next_rand();
				if (r[25:24] != 2'b00) begin
					boot_valid <= 1'b1;
					boot_data  <= words[idx];
					busy = 1'b1;
				end else begin
					boot_valid <= 1'b0;
				end
			end
			@(negedge tb_CLK);
			if (boot_valid && boot_ready) begin
				accept_edge = cycle_count + 1;
				idx++;
				busy = 1'b0;
			end
			@(posedge tb_CLK);
		end
		boot_valid <= 1'b0;
	endtask

	task automatic check_release(input int accept_edge);
		int fall_edge;
		fall_edge = 0;
		for (int i = 0; i < 8 && fall_edge == 0; i++) begin
			@(negedge tb_CLK);
			if (!core_reset) begin
				fall_edge = cycle_count;
			end
		end
		if (fall_edge == 0) begin
			report_failure("core_reset never fell after the boot stream");
		end else if (fall_edge != accept_edge + 2) begin
			report_failure($sformatf("core_reset fell at cycle %0d, expected cycle %0d",
			                         fall_edge, accept_edge + 2));
		end
		check_bit("boot_ready", boot_ready, 1'b0);
		check_bit("fetch_gnt", fetch_gnt, 1'b1);
		check_bit("lsu_gnt", lsu_gnt, 1'b1);
		@(posedge tb_CLK);
	endtask

	// Returns on the rising edge that completes the transfer
	task automatic obi_access(input bit is_lsu, input bit wr, input int waddr,
	                          input logic [3:0] be, input logic [31:0] wdata);
		bit granted;
		int waited;
		if (is_lsu) begin
			lsu_req   <= 1'b1;
			lsu_we    <= wr;
			lsu_addr  <= obi_addr_t'(waddr) << 2;
			lsu_be    <= be;
			lsu_wdata <= wdata;
		end else begin
			fetch_req   <= 1'b1;
			fetch_we    <= wr;
			fetch_addr  <= obi_addr_t'(waddr) << 2;
			fetch_be    <= be;
			fetch_wdata <= wdata;
		end
		granted = 1'b0;
		waited  = 0;
		while (!granted && waited < 16) begin
			@(negedge tb_CLK);
			granted = is_lsu ? lsu_gnt : fetch_gnt;
			waited++;
			@(posedge tb_CLK);
		end
		if (!granted) begin
			report_failure($sformatf("request on port %0d was never granted", is_lsu));
		end
	endtask

	task automatic idle_port(input bit is_lsu);
		if (is_lsu) begin
			lsu_req <= 1'b0;
			lsu_we  <= 1'b0;
		end else begin
			fetch_req <= 1'b0;
			fetch_we  <= 1'b0;
		end
	endtask

	task automatic read_range(input bit is_lsu, input int n);
		for (int a = 0; a < n; a++) begin
			obi_access(is_lsu, 1'b0, a, 4'hf, 32'h0);
		end
		idle_port(is_lsu);
	endtask

	// Responses come one cycle after grant
	task automatic settle();
		repeat (2) @(posedge tb_CLK);
	endtask

	initial begin
		logic [31:0] r;
		reset       = 1'b1;
		boot_valid  = 1'b0;
		boot_data   = '0;
		fetch_req   = 1'b0;
		fetch_addr  = '0;
		fetch_we    = 1'b0;
		fetch_be    = '0;
		fetch_wdata = '0;
		lsu_req     = 1'b0;
		lsu_addr    = '0;
		lsu_we      = 1'b0;
		lsu_be      = '0;
		lsu_wdata   = '0;
		r = next_rand();
		n_imem = 1 + int'(r[21:16]);
		r = next_rand();
		n_dmem = 1 + int'(r[21:16]);
		cycle_limit = 2 * ((1 + n_imem + n_dmem) + 6)
		            + 2 * (4 + 3 * n_imem + 2 * n_dmem + N_WRITES + 5) + 200;

		// Requests parked during boot
		apply_reset();
		park_requests();
		check_idle_after_reset();
		send_boot(n_imem, n_dmem, last_accept);
		check_release(last_accept);
		idle_port(1'b0);
		idle_port(1'b1);
		settle();

		fork
			read_range(1'b0, n_imem);
			read_range(1'b1, n_dmem);
		join
		settle();

		// Byte-masked writes and a read-back of both memories
		for (int i = 0; i < N_WRITES; i++) begin
			r = next_rand();
			obi_access(1'b1, 1'b1, int'(r[31:16]) % n_dmem, r[3:0], next_rand());
		end
		idle_port(1'b1);
		settle();
		fork
			read_range(1'b0, n_imem);
			read_range(1'b1, n_dmem);
		join
		settle();

		// Second boot with a data section only
		apply_reset();
		park_requests();
		check_idle_after_reset();
		send_boot(0, 5, last_accept);
		check_release(last_accept);
		idle_port(1'b0);
		idle_port(1'b1);
		settle();
		fork
			read_range(1'b0, n_imem);
			read_range(1'b1, 5);
		join
		settle();

		finish_run();
	end

endmodule

// File: mem_subsys_top.f
+incdir+.
boot_pkg.sv
obi_pkg.sv
ssram.sv
obi_ssram_bridge.sv
mem_boot_loader.sv
mem_subsys_top.sv
tb_mem_subsys_checker.sv
tb_mem_subsys.sv

// File: Makefile
# Verilator flow for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= mem_subsys_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) mem_settings.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation prints the pass message
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
